// File: common/riscv_pkg.sv
/*
 * riscv core shared definitions
 * width types, opcode and funct3 values, and the control
 * encodings passed between decoders and datapath
 */
`default_nettype none

package riscv_pkg;

        // widths with a meaning
        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [2:0]  alu_ctrl_t;
        typedef logic [1:0]  alu_op_t;
        typedef logic [1:0]  imm_src_t;
        typedef logic [1:0]  result_src_t;

        // base opcodes of the supported subset
        localparam logic [6:0] OP_LOAD   = 7'b0000011;
        localparam logic [6:0] OP_STORE  = 7'b0100011;
        localparam logic [6:0] OP_REG    = 7'b0110011;
        localparam logic [6:0] OP_IMM    = 7'b0010011;
        localparam logic [6:0] OP_BRANCH = 7'b1100011;
        localparam logic [6:0] OP_JAL    = 7'b1101111;

        // funct3 of register and immediate ops
        localparam logic [2:0] F3_ADD_SUB = 3'b000;
        localparam logic [2:0] F3_SLT     = 3'b010;
        localparam logic [2:0] F3_OR      = 3'b110;
        localparam logic [2:0] F3_AND     = 3'b111;

        // alu operations, unlisted codes give zero
        localparam alu_ctrl_t ALU_ADD  = 3'b000;
        localparam alu_ctrl_t ALU_SUB  = 3'b001;
        localparam alu_ctrl_t ALU_AND  = 3'b010;
        localparam alu_ctrl_t ALU_OR   = 3'b011;
        localparam alu_ctrl_t ALU_SLT  = 3'b101;
        localparam alu_ctrl_t ALU_NONE = 3'b111;

        // operation class from main decoder
        localparam alu_op_t ALU_OP_ADD   = 2'b00;
        localparam alu_op_t ALU_OP_SUB   = 2'b01;
        localparam alu_op_t ALU_OP_FUNCT = 2'b10;

        // immediate formats
        localparam imm_src_t IMM_I = 2'b00;
        localparam imm_src_t IMM_S = 2'b01;
        localparam imm_src_t IMM_B = 2'b10;
        localparam imm_src_t IMM_J = 2'b11;

        // write-back sources
        localparam result_src_t RES_ALU = 2'b00;
        localparam result_src_t RES_MEM = 2'b01;
        localparam result_src_t RES_PC4 = 2'b10;

endpackage

`default_nettype wire

// File: control/main_decoder.sv
/*
 * main decoder
 * maps the opcode onto the datapath control levels,
 * unknown opcodes come out as no-ops
 */
`timescale 1ns/1ps
`default_nettype none

module main_decoder
        import riscv_pkg::*;
(
        input  wire [6:0]   opcode,
        output logic        branch,
        output logic        jump,
        output result_src_t result_src,
        output logic        mem_write,
        output logic        alu_src,
        output imm_src_t    imm_src,
        output logic        reg_write,
        output alu_op_t     alu_op
);

        // one row per opcode
        // reg_write, imm_src, alu_src, mem_write, result_src, branch, alu_op, jump
        always_comb
        begin
                case (opcode)
                        OP_LOAD:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b1, IMM_I, 1'b1, 1'b0, RES_MEM, 1'b0, ALU_OP_ADD, 1'b0};
                        OP_STORE:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b0, IMM_S, 1'b1, 1'b1, RES_ALU, 1'b0, ALU_OP_ADD, 1'b0};
                        OP_REG:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b1, IMM_I, 1'b0, 1'b0, RES_ALU, 1'b0, ALU_OP_FUNCT, 1'b0};
                        OP_IMM:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b1, IMM_I, 1'b1, 1'b0, RES_ALU, 1'b0, ALU_OP_FUNCT, 1'b0};
                        // beq compares by subtracting
                        OP_BRANCH:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b0, IMM_B, 1'b0, 1'b0, RES_ALU, 1'b1, ALU_OP_SUB, 1'b0};
                        // jal links pc plus 4
                        OP_JAL:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b1, IMM_J, 1'b0, 1'b0, RES_PC4, 1'b0, ALU_OP_ADD, 1'b1};
                        // no writes, no pc change
                        default:
                                {reg_write, imm_src, alu_src, mem_write, result_src,
                                 branch, alu_op, jump} =
                                {1'b0, IMM_I, 1'b0, 1'b0, RES_ALU, 1'b0, ALU_OP_ADD, 1'b0};
                endcase
        end

endmodule

`default_nettype wire

// File: control/alu_decoder.sv
/*
 * alu decoder
 * turns the operation class, funct3 and funct7 bit 5
 * into the alu operation code
 */
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
        import riscv_pkg::*;
(
        input  wire alu_op_t   alu_op,
        input  wire [2:0]      funct3,
        input  wire            funct7_b5,
        input  wire            op_b5,
        output alu_ctrl_t      alu_ctrl
);

        always_comb
        begin
                case (alu_op)
                        // loads, stores, jal
                        ALU_OP_ADD: alu_ctrl = ALU_ADD;
                        // beq
                        ALU_OP_SUB: alu_ctrl = ALU_SUB;
                        default:
                        begin
                                case (funct3)
                                        // sub only for register form, addi has funct7 bits of imm
                                        F3_ADD_SUB: alu_ctrl = (funct7_b5 & op_b5) ? ALU_SUB : ALU_ADD;
                                        F3_SLT:     alu_ctrl = ALU_SLT;
                                        F3_OR:      alu_ctrl = ALU_OR;
                                        F3_AND:     alu_ctrl = ALU_AND;
                                        default:    alu_ctrl = ALU_NONE;
                                endcase
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: control/controller.sv
/*
 * controller
 * main and alu decoders, pc select from branch, jump and
 * zero, write enables held off during reset
 */
`timescale 1ns/1ps
`default_nettype none

module controller
        import riscv_pkg::*;
(
        input  wire          rst_n,
        input  wire [6:0]    opcode,
        input  wire [2:0]    funct3,
        input  wire          funct7_b5,
        input  wire          zero,
        output logic         pc_src,
        output result_src_t  result_src,
        output logic         mem_write,
        output logic         alu_src,
        output imm_src_t     imm_src,
        output logic         reg_write,
        output alu_ctrl_t    alu_ctrl
);

        logic    branch;
        logic    jump;
        logic    mem_write_dec;
        logic    reg_write_dec;
        alu_op_t alu_op;

        main_decoder i_main_decoder (
                .opcode     (opcode),
                .branch     (branch),
                .jump       (jump),
                .result_src (result_src),
                .mem_write  (mem_write_dec),
                .alu_src    (alu_src),
                .imm_src    (imm_src),
                .reg_write  (reg_write_dec),
                .alu_op     (alu_op)
        );

        // opcode bit 5 separates register ops from immediate ops
        alu_decoder i_alu_decoder (
                .alu_op    (alu_op),
                .funct3    (funct3),
                .funct7_b5 (funct7_b5),
                .op_b5     (opcode[5]),
                .alu_ctrl  (alu_ctrl)
        );

        // taken beq or jal
        assign pc_src = (branch & zero) | jump;

        // no state changes while in reset
        assign mem_write = mem_write_dec & rst_n;
        assign reg_write = reg_write_dec & rst_n;

endmodule

`default_nettype wire

// File: datapath/alu.sv
/*
 * alu
 * add, subtract, and, or and signed set-less-than,
 * zero flag for beq
 */
`timescale 1ns/1ps
`default_nettype none

module alu
        import riscv_pkg::*;
(
        input  wire word_t      a_in,
        input  wire word_t      b_in,
        input  wire alu_ctrl_t  alu_ctrl,
        output word_t           alu_result,
        output logic            zero
);

        always_comb
        begin
                case (alu_ctrl)
                        // add, addi, address calc
                        ALU_ADD: alu_result = a_in + b_in;

                        // two's complement sub
                        ALU_SUB: alu_result = a_in + (~b_in + 32'd1);

                        // and, andi
                        ALU_AND: alu_result = a_in & b_in;

                        // or, ori
                        ALU_OR:  alu_result = a_in | b_in;

                        // slt, slti
                        // both sides signed
                        ALU_SLT: alu_result = ($signed(a_in) < $signed(b_in)) ? 32'd1 : 32'd0;

                        default: alu_result = '0;
                endcase
        end

        // high on equal operands for sub
        assign zero = (alu_result == '0);

endmodule

`default_nettype wire

// File: datapath/reg_file.sv
/*
 * register file
 * 32 x 32 bit, two combinational reads, one write at
 * the clock edge, x0 reads zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file
        import riscv_pkg::*;
(
        input  wire             clk,
        input  wire             rst_n,
        input  wire reg_addr_t  addr1,
        input  wire reg_addr_t  addr2,
        input  wire reg_addr_t  addr3,
        input  wire             write_enable,
        input  wire word_t      write_value,
        output word_t           read1,
        output word_t           read2
);

        word_t regs [32];

        // cleared at reset, x0 never written
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                begin
                        for (int i = 0; i < 32; i++)
                                regs[i] <= '0;
                end
                else if (write_enable && (addr3 != '0))
                begin
                        regs[addr3] <= write_value;
                end
        end

        // x0 stays at its reset value of zero
        assign read1 = regs[addr1];
        assign read2 = regs[addr2];

endmodule

`default_nettype wire

// File: datapath/datapath.sv
/*
 * datapath
 * pc register and next pc, immediate extension,
 * alu operand and write-back muxes, register file and alu
 */
`timescale 1ns/1ps
`default_nettype none

module datapath
        import riscv_pkg::*;
(
        input  wire              clk,
        input  wire              rst_n,
        input  wire word_t       instr,
        output word_t            pc,
        input  wire              pc_src,
        input  wire result_src_t result_src,
        input  wire              alu_src,
        input  wire imm_src_t    imm_src,
        input  wire              reg_write,
        input  wire alu_ctrl_t   alu_ctrl,
        input  wire word_t       read_data,
        output logic [6:0]       opcode,
        output logic [2:0]       funct3,
        output logic             funct7_b5,
        output logic             zero,
        output word_t            alu_result,
        output word_t            write_data
);

        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm_ext;
        word_t     pc_plus4;
        word_t     pc_target;
        word_t     pc_next;
        word_t     src_a;
        word_t     src_b;
        word_t     result;

        // instruction fields
        assign opcode    = instr[6:0];
        assign funct3    = instr[14:12];
        assign funct7_b5 = instr[30];
        assign rs1       = instr[19:15];
        assign rs2       = instr[24:20];
        assign rd        = instr[11:7];

        // next pc
        assign pc_plus4  = pc + 32'd4;
        assign pc_target = pc + imm_ext;
        assign pc_next   = pc_src ? pc_target : pc_plus4;

        // first fetch at address 0
        always_ff @(posedge clk or negedge rst_n)
        begin
                if (!rst_n)
                        pc <= '0;
                else
                        pc <= pc_next;
        end

        // sign extension, bit 31 always the sign
        always_comb
        begin
                case (imm_src)
                        IMM_I:   imm_ext = {{20{instr[31]}}, instr[31:20]};
                        IMM_S:   imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                        // branch offsets in halfwords
                        IMM_B:   imm_ext = {{20{instr[31]}}, instr[7], instr[30:25],
                                            instr[11:8], 1'b0};
                        default: imm_ext = {{12{instr[31]}}, instr[19:12], instr[20],
                                            instr[30:21], 1'b0};
                endcase
        end

        reg_file i_reg_file (
                .clk          (clk),
                .rst_n        (rst_n),
                .addr1        (rs1),
                .addr2        (rs2),
                .addr3        (rd),
                .write_enable (reg_write),
                .write_value  (result),
                .read1        (src_a),
                .read2        (write_data)
        );

        // immediate or rs2
        assign src_b = alu_src ? imm_ext : write_data;

        alu i_alu (
                .a_in       (src_a),
                .b_in       (src_b),
                .alu_ctrl   (alu_ctrl),
                .alu_result (alu_result),
                .zero       (zero)
        );

        // write-back select
        always_comb
        begin
                case (result_src)
                        RES_MEM: result = read_data;
                        RES_PC4: result = pc_plus4;
                        default: result = alu_result;
                endcase
        end

endmodule

`default_nettype wire

// File: src/data_memory.sv
/*
 * data memory
 * word-addressed ram, write at the clock edge, combinational
 * read, index wraps over the depth
 */
`timescale 1ns/1ps
`default_nettype none

module data_memory
        import riscv_pkg::*;
#(
        parameter int DMEM_WORDS = 64
) (
        input  wire         clk,
        input  wire word_t  addr,
        input  wire         write_enable,
        input  wire word_t  write_value,
        output word_t       read_value
);

        localparam int IDX_W = $clog2(DMEM_WORDS);

        word_t             mem [DMEM_WORDS];
        logic [IDX_W-1:0]  idx;

        // byte offset dropped, upper bits wrap
        assign idx = addr[IDX_W+1:2];

        always_ff @(posedge clk)
        begin
                if (write_enable)
                        mem[idx] <= write_value;
        end

        assign read_value = mem[idx];

endmodule

`default_nettype wire

// File: src/riscv_single.sv
/*
 * single-cycle rv32i core, subset
 * controller, datapath and data memory, instruction
 * memory outside, store port visible at the top
 */
`timescale 1ns/1ps
`default_nettype none

module riscv_single
        import riscv_pkg::*;
#(
        parameter int DMEM_WORDS = 64
) (
        input  wire         clk,
        input  wire         rst_n,
        output word_t       pc,
        input  wire word_t  instr,
        output logic        mem_write,
        output word_t       data_addr,
        output word_t       write_data
);

        logic        pc_src;
        logic        alu_src;
        logic        reg_write;
        logic        zero;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic        funct7_b5;
        result_src_t result_src;
        imm_src_t    imm_src;
        alu_ctrl_t   alu_ctrl;
        word_t       read_data;

        controller i_controller (
                .rst_n      (rst_n),
                .opcode     (opcode),
                .funct3     (funct3),
                .funct7_b5  (funct7_b5),
                .zero       (zero),
                .pc_src     (pc_src),
                .result_src (result_src),
                .mem_write  (mem_write),
                .alu_src    (alu_src),
                .imm_src    (imm_src),
                .reg_write  (reg_write),
                .alu_ctrl   (alu_ctrl)
        );

        // alu result doubles as the data address
        datapath i_datapath (
                .clk        (clk),
                .rst_n      (rst_n),
                .instr      (instr),
                .pc         (pc),
                .pc_src     (pc_src),
                .result_src (result_src),
                .alu_src    (alu_src),
                .imm_src    (imm_src),
                .reg_write  (reg_write),
                .alu_ctrl   (alu_ctrl),
                .read_data  (read_data),
                .opcode     (opcode),
                .funct3     (funct3),
                .funct7_b5  (funct7_b5),
                .zero       (zero),
                .alu_result (data_addr),
                .write_data (write_data)
        );

        data_memory #(
                .DMEM_WORDS (DMEM_WORDS)
        ) i_data_memory (
                .clk          (clk),
                .addr         (data_addr),
                .write_enable (mem_write),
                .write_value  (write_data),
                .read_value   (read_data)
        );

endmodule

`default_nettype wire

// File: tb/tb_riscv_single.sv
/*
 * testbench for the single-cycle rv32i core
 * random forward-only program, instruction fetch model,
 * architectural reference model checked every cycle
 */
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_single
        import riscv_pkg::*;
;

        localparam int    DMEM_WORDS = 64;
        // init block, random body, dump of x0..x31, final self-loop
        localparam int    N_INIT     = 25;
        localparam int    N_RAND     = 170;
        localparam int    DUMP_START = N_INIT + N_RAND;
        localparam int    PROG_LEN   = DUMP_START + 33;
        localparam word_t END_PC     = word_t'((PROG_LEN - 1) * 4);

        logic  clk;
        logic  rst_n;
        word_t pc;
        word_t instr;
        logic  mem_write;
        word_t data_addr;
        word_t write_data;

        word_t prog [256];
        word_t rng_state = 32'd99636;
        int    gen_pos;
        int    end_seen;

        // architectural model state
        word_t m_pc;
        word_t m_regs [32];
        word_t m_mem [DMEM_WORDS];
        logic  exp_store;
        word_t exp_addr;
        word_t exp_wdata;

        riscv_single #(
                .DMEM_WORDS (DMEM_WORDS)
        ) i_riscv_single (
                .clk        (clk),
                .rst_n      (rst_n),
                .pc         (pc),
                .instr      (instr),
                .mem_write  (mem_write),
                .data_addr  (data_addr),
                .write_data (write_data)
        );

        initial
        begin
                clk = 1'b1;
                forever #2 clk = ~clk;
        end

        function automatic word_t rand32();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        // instruction encoders
        function automatic word_t enc_r(input logic [2:0] f3, input logic f7b5,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input reg_addr_t rs2);
                return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, OP_REG};
        endfunction

        function automatic word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                        input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
                return {imm, rs1, f3, rd, op};
        endfunction

        function automatic word_t enc_s(input reg_addr_t rs2, input reg_addr_t rs1,
                                        input logic [11:0] imm);
                return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
        endfunction

        function automatic word_t enc_b(input reg_addr_t rs1, input reg_addr_t rs2,
                                        input logic [12:0] off);
                return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
        endfunction

        function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] off);
                return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
        endfunction

        task automatic put(input word_t w);
                prog[gen_pos] = w;
                gen_pos++;
        endtask

        task automatic build_program();
                word_t       r;
                word_t       imm;
                int          d;
                logic [11:0] off;
                // unused slots hold addi x0 no-ops tagged with their index
                for (int i = 0; i < 256; i++)
                        prog[i] = enc_i(OP_IMM, F3_ADD_SUB, 5'd0, 5'd0, 12'(i));
                gen_pos = 0;
                // a store first, so reset has a store to hold off
                put(enc_s(5'd0, 5'd0, 12'd0));
                for (int k = 1; k <= 8; k++)
                begin
                        imm = rand32();
                        put(enc_i(OP_IMM, F3_ADD_SUB, 5'(k), 5'd0, imm[11:0]));
                end
                // words 0..15 get known values before any load
                for (int k = 0; k < 16; k++)
                        put(enc_s(5'(1 + k % 8), 5'd0, 12'(4 * k)));
                for (int i = N_INIT; i < DUMP_START; i++)
                begin
                        r   = rand32();
                        imm = rand32();
                        // forward target, never past the dump
                        d = 1 + int'(r[17:15]) % 6;
                        if (d > DUMP_START - i)
                                d = DUMP_START - i;
                        // word 0..15, aliased by -64, 0, +64 or +128 words
                        off = 12'(4 * int'(r[18:15]) + 256 * int'(r[20:19]) - 256);
                        case (r[31:28])
                                4'd0:  put(enc_r(F3_ADD_SUB, 1'b0, r[4:0], r[9:5], r[14:10]));
                                4'd1:  put(enc_r(F3_ADD_SUB, 1'b1, r[4:0], r[9:5], r[14:10]));
                                4'd2:  put(enc_r(F3_AND, 1'b0, r[4:0], r[9:5], r[14:10]));
                                4'd3:  put(enc_r(F3_OR, 1'b0, r[4:0], r[9:5], r[14:10]));
                                4'd4:  put(enc_r(F3_SLT, 1'b0, r[4:0], r[9:5], r[14:10]));
                                4'd5:  put(enc_i(OP_IMM, F3_ADD_SUB, r[4:0], r[9:5], imm[11:0]));
                                4'd6:  put(enc_i(OP_IMM, F3_AND, r[4:0], r[9:5], imm[11:0]));
                                4'd7:  put(enc_i(OP_IMM, F3_OR, r[4:0], r[9:5], imm[11:0]));
                                4'd8:  put(enc_i(OP_IMM, F3_SLT, r[4:0], r[9:5], imm[11:0]));
                                4'd9,
                                4'd10: put(enc_i(OP_LOAD, 3'b010, r[4:0], 5'd0, off));
                                4'd11,
                                4'd12: put(enc_s(r[14:10], 5'd0, off));
                                // same register on both sides half the time, so taken
                                4'd13,
                                4'd14: put(enc_b(r[9:5], r[21] ? r[9:5] : r[14:10], 13'(d * 4)));
                                default: put(enc_j(r[4:0], 21'(d * 4)));
                        endcase
                end
                for (int n = 0; n < 32; n++)
                        put(enc_s(5'(n), 5'd0, 12'(4 * n)));
                put(enc_j(5'd0, 21'd0));
        endtask

        function automatic int word_index(input word_t addr);
                return int'(addr >> 2) % DMEM_WORDS;
        endfunction

        function automatic word_t arith(input logic [2:0] f3, input logic sub,
                                        input word_t a, input word_t b);
                case (f3)
                        F3_ADD_SUB: return sub ? a - b : a + b;
                        F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F3_OR:      return a | b;
                        F3_AND:     return a & b;
                        default:    return 32'd0;
                endcase
        endfunction

        // one instruction on the model, sets the expected store
        function automatic void exec_ref(input word_t ins);
                reg_addr_t rd;
                reg_addr_t rs1;
                reg_addr_t rs2;
                word_t     a;
                word_t     b;
                word_t     imm_i;
                word_t     imm_s;
                word_t     imm_b;
                word_t     imm_j;
                word_t     res;
                word_t     next_pc;
                logic      wr;
                rd      = ins[11:7];
                rs1     = ins[19:15];
                rs2     = ins[24:20];
                a       = m_regs[rs1];
                b       = m_regs[rs2];
                imm_i   = {{20{ins[31]}}, ins[31:20]};
                imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                next_pc   = m_pc + 32'd4;
                wr        = 1'b0;
                res       = 32'd0;
                exp_store = 1'b0;
                exp_addr  = 32'd0;
                exp_wdata = 32'd0;
                case (ins[6:0])
                        OP_REG:
                        begin
                                wr  = 1'b1;
                                res = arith(ins[14:12], ins[30], a, b);
                        end
                        // immediate forms never subtract
                        OP_IMM:
                        begin
                                wr  = 1'b1;
                                res = arith(ins[14:12], 1'b0, a, imm_i);
                        end
                        OP_LOAD:
                        begin
                                wr  = 1'b1;
                                res = m_mem[word_index(a + imm_i)];
                        end
                        OP_STORE:
                        begin
                                exp_store = 1'b1;
                                exp_addr  = a + imm_s;
                                exp_wdata = b;
                                m_mem[word_index(exp_addr)] = b;
                        end
                        OP_BRANCH:
                        begin
                                if (a == b)
                                        next_pc = m_pc + imm_b;
                        end
                        OP_JAL:
                        begin
                                wr      = 1'b1;
                                res     = m_pc + 32'd4;
                                next_pc = m_pc + imm_j;
                        end
                        default: ;
                endcase
                if (wr && rd != 5'd0)
                        m_regs[rd] = res;
                m_pc = next_pc;
        endfunction

        task automatic fail_now(input string msg);
                $display("%s", msg);
                $display("Result: FAILED");
                $fatal(1, "stopped at first error");
        endtask

        task automatic check_word(input string name, input word_t act, input word_t exp);
                if (act !== exp)
                        fail_now($sformatf("FAILED %s: got 0x%08h, expected 0x%08h",
                                           name, act, exp));
        endtask

        task automatic check_bit(input string name, input logic act, input logic exp);
                if (act !== exp)
                        fail_now($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                                           name, act, exp));
        endtask

        // instruction fetch, follows pc at each falling edge
        initial
        begin
                forever
                begin
                        @(negedge clk);
                        instr = prog[pc[9:2]];
                end
        end

        initial
        begin
                repeat (PROG_LEN * 3 + 100) @(posedge clk);
                fail_now("timeout: the program never reached its final loop");
        end

        initial
        begin
                build_program();
                rst_n    = 1'b0;
                instr    = prog[0];
                m_pc     = 32'd0;
                end_seen = 0;
                for (int i = 0; i < 32; i++)
                        m_regs[i] = 32'd0;
                // pc parked and store blocked during reset
                repeat (4)
                begin
                        @(negedge clk);
                        #1;
                        check_word("pc", pc, 32'd0);
                        check_bit("mem_write", mem_write, 1'b0);
                end
                @(negedge clk);
                rst_n = 1'b1;
                // sample one ns after the falling edge
                while (end_seen < 3)
                begin
                        #1;
                        check_word("pc", pc, m_pc);
                        exec_ref(prog[m_pc[9:2]]);
                        check_bit("mem_write", mem_write, exp_store);
                        if (exp_store)
                        begin
                                check_word("data_addr", data_addr, exp_addr);
                                check_word("write_data", write_data, exp_wdata);
                        end
                        if (m_pc == END_PC)
                                end_seen++;
                        @(negedge clk);
                end
                $display("Result: PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// File: riscv_single.f
common/riscv_pkg.sv
control/main_decoder.sv
control/alu_decoder.sv
control/controller.sv
datapath/alu.sv
datapath/reg_file.sv
datapath/datapath.sv
src/data_memory.sv
src/riscv_single.sv
tb/tb_riscv_single.sv

// File: run_sim.sh
#!/bin/sh
# build and run the riscv_single testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
        --top-module tb_riscv_single -f riscv_single.f

./obj_dir/Vtb_riscv_single 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
        echo "simulation failed, see sim.log"
        exit 1
fi
echo "simulation passed"
